//--- fofb_link.f
+incdir+hdl
hdl/fofb_pkg.sv
hdl/setpoint_stash.sv
hdl/setpoint_tx.sv
hdl/readback_rx.sv
hdl/fofb_link.sv
tb/fofb_link_asserts.sv
tb/fofb_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fofb_link testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fofb_link.f \
  --top-module fofb_link_tb --Mdir obj_dir -o Vfofb_link_tb

status=0
./obj_dir/Vfofb_link_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"

//--- tb/fofb_stim.txt
// op aux value. 0C command, 01/02 kept beat (02 last), 03/04 dropped beat, 05 serve packet
// (value = length), 06 idle cycles, 07 rx ready, 08 rx header (aux = bad byte, FF none),
// 09 rx record (aux = supply), 0A expected hdr_bad, FF end
0C 00 00000005
01 00 11223344
01 00 A5A5F00D
02 00 DEADBEEF
03 00 00000001  // arrives while frame above is pending
04 00 00000002
05 00 0000001E  // 12 + 6 * 3
06 00 00000014  // dropped frame must stay quiet
01 00 01020304
02 00 80000001
05 00 00000018  // 12 + 6 * 2
07 00 00000000
08 FF 00000000
09 00 12345678
09 1F CAFEF00D
0A 00 00000000
07 00 00000000
08 01 00000000  // second magic byte flipped
09 02 00000042
0A 00 00000001
07 00 00000000
0A 00 00000000
08 0B 00000000  // last nonce byte flipped
0A 00 00000001
FF 00 00000000

//--- tb/fofb_link_tb.sv
// Testbench for the fast orbit feedback link. Plays frames and readback payloads
// from tb/fofb_stim.txt, acts as the MAC client and checks bytes and records.

`timescale 1ns/100ps

`include "fofb_consts.svh"

module fofb_link_tb;

  localparam int STIM_WORDS = 192;  // three words per stimulus line

  logic                     ethClk;
  logic                     arst_n;
  fofb_pkg::setpoint_beat_t beat;
  logic [`FOFB_CMD_W-1:0]   readback_cmd;
  fofb_pkg::tx_status_t     tx_status;
  fofb_pkg::rx_byte_t       rx_byte;
  fofb_pkg::tx_request_t    tx_req;
  logic [7:0]               data_tx;
  fofb_pkg::rx_record_t     record;
  logic                     hdr_bad;

  logic [31:0]              stim [0:STIM_WORDS-1];
  logic [31:0]              frame_q [$];      // kept setpoints awaiting transmit
  logic [`FOFB_NONCE_W-1:0] exp_nonce;
  int                       seed = 28;
  int                       cycle_cnt = 0;
  int                       cycle_limit = 100000;

  fofb_link dut0 (
    .ethClk       (ethClk),
    .arst_n       (arst_n),
    .beat         (beat),
    .readback_cmd (readback_cmd),
    .tx_status    (tx_status),
    .rx_byte      (rx_byte),
    .tx_req       (tx_req),
    .data_tx      (data_tx),
    .record       (record),
    .hdr_bad      (hdr_bad)
  );

  bind fofb_link fofb_link_asserts u_asserts (
    .ethClk    (ethClk),
    .arst_n    (arst_n),
    .tx_status (tx_status),
    .tx_req    (tx_req),
    .record    (record),
    .tx_busy   (u_tx.busy)
  );

  always #50 ethClk = ~ethClk;

  always @(posedge ethClk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run("timeout, the DUT stopped responding");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_length(input string name, input fofb_pkg::tx_request_t exp,
                              input fofb_pkg::tx_request_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected req %b length %0d, actual req %b length %0d",
                          name, exp.req, exp.length, act.req, act.length));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_record(input string name, input fofb_pkg::rx_record_t exp,
                              input fofb_pkg::rx_record_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %b/%h/%h, actual %b/%h/%h", name,
                          exp.valid, exp.supply, exp.value, act.valid, act.supply, act.value));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  // header byte by position in wire order
  function automatic logic [7:0] header_byte(input int idx);
    case (idx)
      0:       return 8'h76;
      1:       return 8'h31;
      2:       return 8'h00;
      3:       return {4'h0, readback_cmd};
      default: return exp_nonce[8 * (11 - idx) +: 8];
    endcase
  endfunction

  function automatic int stim_bytes();
    int total;
    int pc;
    total = 0;
    pc = 0;
    while (pc < STIM_WORDS && stim[pc][7:0] !== 8'hFF) begin
      case (stim[pc][7:0])
        8'h05, 8'h06: total += int'(stim[pc + 2]);
        8'h08:        total += `FOFB_HDR_BYTES;
        8'h09:        total += `FOFB_REC_BYTES;
        default:      total += 1;
      endcase
      pc += 3;
    end
    return total;
  endfunction

  task automatic random_gap();
    repeat ($unsigned($random(seed)) % 4) @(posedge ethClk);
  endtask

  task automatic drive_beat(input logic last, input logic [31:0] value);
    @(posedge ethClk);
    beat.valid <= 1'b1;
    beat.last  <= last;
    beat.value <= value;
  endtask

  task automatic end_beats();
    @(posedge ethClk);
    beat.valid <= 1'b0;
    beat.last  <= 1'b0;
  endtask

  // MAC client side of one transmitted packet
  task automatic serve_packet(input int len);
    fofb_pkg::tx_request_t exp_req;
    logic [7:0]            exp_bytes [$];
    exp_nonce = exp_nonce + 1'b1;
    for (int i = 0; i < `FOFB_HDR_BYTES; i++) begin
      exp_bytes.push_back(header_byte(i));
    end
    foreach (frame_q[s]) begin
      exp_bytes.push_back(8'h00);
      exp_bytes.push_back(8'(s));
      for (int b = 3; b >= 0; b--) begin
        exp_bytes.push_back(frame_q[s][8 * b +: 8]);
      end
    end
    if (exp_bytes.size() != len) begin
      abort_run("stimulus file length does not fit the frame");
    end
    exp_req.req    = 1'b1;
    exp_req.length = len[`FOFB_LEN_W-1:0];
    @(negedge ethClk);
    while (!tx_req.req) begin
      @(negedge ethClk);
    end
    check_length($sformatf("packet %0d request", exp_nonce), exp_req, tx_req);
    @(posedge ethClk);
    tx_status.ack <= 1'b1;
    @(posedge ethClk);
    tx_status.ack <= 1'b0;
    for (int i = 0; i < len; i++) begin
      @(negedge ethClk);
      check_byte($sformatf("packet %0d byte %0d", exp_nonce, i), exp_bytes[i], data_tx);
      random_gap();
      @(posedge ethClk);
      tx_status.strobe <= 1'b1;
      tx_status.warn   <= (i != len - 1);  // low marks the final byte
      @(posedge ethClk);
      tx_status.strobe <= 1'b0;
    end
    frame_q.delete();
  endtask

  task automatic send_rx_byte(input logic [7:0] data);
    random_gap();
    @(posedge ethClk);
    rx_byte.strobe <= 1'b1;
    rx_byte.data   <= data;
    @(posedge ethClk);
    rx_byte.strobe <= 1'b0;
  endtask

  task automatic send_rx_header(input int bad_pos);
    logic [7:0] data;
    for (int i = 0; i < `FOFB_HDR_BYTES; i++) begin
      data = header_byte(i);
      if (i == bad_pos) begin
        data = ~data;
      end
      send_rx_byte(data);
    end
  endtask

  task automatic send_rx_record(input logic [7:0] supply, input logic [31:0] value);
    fofb_pkg::rx_record_t exp_rec;
    exp_rec.valid  = 1'b1;
    exp_rec.supply = supply;
    exp_rec.value  = value;
    send_rx_byte(8'h00);
    send_rx_byte(supply);
    for (int b = 3; b >= 0; b--) begin
      send_rx_byte(value[8 * b +: 8]);
    end
    @(negedge ethClk);
    check_record($sformatf("readback supply %0d", supply), exp_rec, record);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    int          pc;
    logic [7:0]  op;
    logic [7:0]  aux;
    logic [31:0] val;
    ethClk       = 1'b0;
    arst_n       = 1'b0;
    beat         = '0;
    readback_cmd = '0;
    tx_status    = '0;
    rx_byte      = '0;
    exp_nonce    = '0;
    $readmemh("tb/fofb_stim.txt", stim);
    cycle_limit = 2000 + 40 * stim_bytes();
    repeat (16) @(posedge ethClk);
    arst_n <= 1'b1;
    repeat (4) begin
      @(negedge ethClk);
      check_flag("idle req", 1'b0, tx_req.req);
      check_flag("idle record valid", 1'b0, record.valid);
      check_flag("idle hdr_bad", 1'b0, hdr_bad);
    end
    pc = 0;
    op = stim[0][7:0];
    while (op !== 8'hFF) begin
      aux = stim[pc + 1][7:0];
      val = stim[pc + 2];
      if (op > 8'h04) begin
        end_beats();
      end
      case (op)
        8'h01: begin
          frame_q.push_back(val);
          drive_beat(1'b0, val);
        end
        8'h02: begin
          frame_q.push_back(val);
          drive_beat(1'b1, val);
        end
        8'h03: drive_beat(1'b0, val);
        8'h04: drive_beat(1'b1, val);
        8'h05: serve_packet(int'(val));
        8'h06: begin
          repeat (val) begin
            @(negedge ethClk);
            check_flag("no packet for dropped frame", 1'b0, tx_req.req);
          end
        end
        8'h07: begin
          @(posedge ethClk);
          rx_byte.ready <= 1'b1;
          @(posedge ethClk);
          rx_byte.ready <= 1'b0;
        end
        8'h08: send_rx_header(int'(aux));
        8'h09: send_rx_record(aux, val);
        8'h0A: begin
          @(negedge ethClk);
          check_flag("header flag", val[0], hdr_bad);
        end
        8'h0C: begin
          @(posedge ethClk);
          readback_cmd <= val[`FOFB_CMD_W-1:0];
        end
        default: abort_run($sformatf("unknown stimulus opcode %h at word %0d", op, pc));
      endcase
      pc += 3;
      op = stim[pc][7:0];
    end
    end_beats();
    repeat (4) @(posedge ethClk);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- tb/fofb_link_asserts.sv
// Concurrent checks on the MAC client handshakes and the readback record pulse.
// Bound onto the link top level by the testbench.

`timescale 1ns/100ps

module fofb_link_asserts (
  input logic                  ethClk,
  input logic                  arst_n,
  input fofb_pkg::tx_status_t  tx_status,
  input fofb_pkg::tx_request_t tx_req,
  input fofb_pkg::rx_record_t  record,
  input logic                  tx_busy
);

  // req has to be gone by the cycle after the client ack
  req_drops_after_ack: assert property (
    @(posedge ethClk) disable iff (!arst_n)
    tx_status.ack |=> !tx_req.req
  ) else $error("req still high after ack");

  strobe_only_when_busy: assert property (
    @(posedge ethClk) disable iff (!arst_n)
    tx_status.strobe |-> tx_busy
  ) else $error("byte strobe while the builder is idle");

  record_valid_pulse: assert property (
    @(posedge ethClk) disable iff (!arst_n)
    record.valid |=> !record.valid
  ) else $error("record valid held longer than one cycle");

endmodule

//--- hdl/fofb_link.sv
// Fast orbit feedback Ethernet client core. Setpoint frames go into the
// stash, out through the builder to the MAC client; readback payloads from
// the client come back through the parser as supply records.

`timescale 1ns/100ps

`include "fofb_consts.svh"

module fofb_link (
  input  logic                       ethClk,
  input  logic                       arst_n,
  input  fofb_pkg::setpoint_beat_t   beat,
  input  logic [`FOFB_CMD_W-1:0]     readback_cmd,
  input  fofb_pkg::tx_status_t       tx_status,
  input  fofb_pkg::rx_byte_t         rx_byte,
  output fofb_pkg::tx_request_t      tx_req,
  output logic [7:0]                 data_tx,
  output fofb_pkg::rx_record_t       record,
  output logic                       hdr_bad
);

  logic [`FOFB_ADDR_W-1:0]  raddr;
  logic [`FOFB_VALUE_W-1:0] rdata;
  logic                     sent;
  logic                     pending;
  logic [`FOFB_ADDR_W:0]    supply_count;
  logic [`FOFB_NONCE_W-1:0] nonce;   // parser checks against last sent

  //////////////////////////////////////////////////
  // setpoint path
  setpoint_stash u_stash (
    .ethClk       (ethClk),
    .arst_n       (arst_n),
    .beat         (beat),
    .raddr        (raddr),
    .rdata        (rdata),
    .sent         (sent),
    .pending      (pending),
    .supply_count (supply_count)
  );

  setpoint_tx u_tx (
    .ethClk       (ethClk),
    .arst_n       (arst_n),
    .pending      (pending),
    .supply_count (supply_count),
    .raddr        (raddr),
    .rdata        (rdata),
    .sent         (sent),
    .readback_cmd (readback_cmd),
    .req          (tx_req),
    .status       (tx_status),
    .data_tx      (data_tx),
    .nonce        (nonce)
  );

  //////////////////////////////////////////////////
  // readback path
  readback_rx u_rx (
    .ethClk       (ethClk),
    .arst_n       (arst_n),
    .rx           (rx_byte),
    .readback_cmd (readback_cmd),
    .nonce        (nonce),
    .record       (record),
    .hdr_bad      (hdr_bad)
  );

endmodule

//--- hdl/readback_rx.sv
// Readback parser. Walks a received payload in the same layout the builder
// sends, flags header bytes that differ and emits each supply record.

`timescale 1ns/100ps

`include "fofb_consts.svh"

module readback_rx (
  input  logic                       ethClk,
  input  logic                       arst_n,
  input  fofb_pkg::rx_byte_t         rx,
  input  logic [`FOFB_CMD_W-1:0]     readback_cmd,
  input  logic [`FOFB_NONCE_W-1:0]   nonce,
  output fofb_pkg::rx_record_t       record,
  output logic                       hdr_bad
);

  localparam int         CMD_W    = `FOFB_CMD_W;
  localparam logic [3:0] HDR_LAST = 4'(`FOFB_HDR_BYTES - 1);
  localparam logic [3:0] REC_LAST = 4'(`FOFB_REC_BYTES - 1);

  logic                            in_hdr;
  logic [3:0]                      pos;
  logic                            valid_r;
  logic                            rec_wr;
  logic [0:`FOFB_HDR_BYTES-1][7:0] hdr_bytes;   // what the builder would send
  fofb_pkg::supply_record_u        rec_buf;

  assign hdr_bytes = {`FOFB_MAGIC, 8'h00, {(8 - CMD_W){1'b0}}, readback_cmd, nonce};

  //////////////////////////////////////////////////
  // parse state and header check
  always_ff @(posedge ethClk or negedge arst_n) begin
    if (!arst_n) begin
      in_hdr  <= 1'b1;
      pos     <= '0;
      valid_r <= 1'b0;
      hdr_bad <= 1'b0;
    end else begin
      valid_r <= 1'b0;
      if (rx.ready) begin
        in_hdr  <= 1'b1;  // restart at first header byte
        pos     <= '0;
        hdr_bad <= 1'b0;
      end else if (rx.strobe) begin
        if (in_hdr) begin
          if (rx.data != hdr_bytes[pos]) begin
            hdr_bad <= 1'b1;
          end
          if (pos == HDR_LAST) begin
            in_hdr <= 1'b0;
            pos    <= '0;
          end else begin
            pos <= pos + 1'b1;
          end
        end else begin
          if (pos == '0 && rx.data != 8'h00) begin
            hdr_bad <= 1'b1;  // supply numbers fit one byte
          end
          if (pos == REC_LAST) begin
            pos     <= '0;
            valid_r <= 1'b1;
          end else begin
            pos <= pos + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // record assembly
  assign rec_wr = rx.strobe && !rx.ready && !in_hdr;

  always_ff @(posedge ethClk) begin
    if (rec_wr) begin
      rec_buf.bytes[pos[2:0]] <= rx.data;
    end
  end

  always_comb begin
    record.valid  = valid_r;
    record.supply = rec_buf.fields.supply[7:0];
    record.value  = rec_buf.fields.value;
  end

endmodule

//--- hdl/setpoint_tx.sv
// Transmit builder. Turns a stashed frame into a UDP payload byte stream for
// the MAC client: magic, readback command, nonce, then one 6-byte record per
// supply. Bytes advance only on client strobes.

`timescale 1ns/100ps

`include "fofb_consts.svh"

module setpoint_tx (
  input  logic                         ethClk,
  input  logic                         arst_n,
  input  logic                         pending,
  input  logic [`FOFB_ADDR_W:0]        supply_count,
  output logic [`FOFB_ADDR_W-1:0]      raddr,
  input  logic [`FOFB_VALUE_W-1:0]     rdata,
  output logic                         sent,
  input  logic [`FOFB_CMD_W-1:0]       readback_cmd,
  output fofb_pkg::tx_request_t        req,
  input  fofb_pkg::tx_status_t         status,
  output logic [7:0]                   data_tx,
  output logic [`FOFB_NONCE_W-1:0]     nonce
);

  localparam int          ADDR_W   = `FOFB_ADDR_W;
  localparam int          LEN_W    = `FOFB_LEN_W;
  localparam int          CMD_W    = `FOFB_CMD_W;
  localparam logic [3:0]  HDR_LAST = 4'(`FOFB_HDR_BYTES - 1);
  localparam logic [3:0]  REC_LAST = 4'(`FOFB_REC_BYTES - 1);

  logic                                busy;
  logic                                in_hdr;      // header bytes still going out
  logic [3:0]                          pos;         // byte within header or record
  logic [7:0]                          supply_idx;
  logic [LEN_W-1:0]                    pkt_len;
  logic [0:`FOFB_HDR_BYTES-1][7:0]     hdr_bytes;
  fofb_pkg::supply_record_u            rec;

  //////////////////////////////////////////////////
  // byte selection
  assign hdr_bytes = {`FOFB_MAGIC, 8'h00, {(8 - CMD_W){1'b0}}, readback_cmd, nonce};

  always_comb begin
    rec.fields.supply = {8'h00, supply_idx};
    rec.fields.value  = rdata;  // RAM word for this supply
  end

  assign raddr   = supply_idx[ADDR_W-1:0];
  assign data_tx = in_hdr ? hdr_bytes[pos] : rec.bytes[pos[2:0]];

  assign pkt_len = LEN_W'(`FOFB_HDR_BYTES) +
                   LEN_W'(`FOFB_REC_BYTES) * LEN_W'(supply_count);

  //////////////////////////////////////////////////
  // packet sequencer
  always_ff @(posedge ethClk or negedge arst_n) begin
    if (!arst_n) begin
      busy       <= 1'b0;
      sent       <= 1'b0;
      req        <= '0;
      nonce      <= '0;
      in_hdr     <= 1'b1;
      pos        <= '0;
      supply_idx <= '0;
    end else begin
      sent <= 1'b0;
      if (busy) begin
        if (status.ack) begin
          req.req <= 1'b0;
        end
        if (status.strobe) begin
          if (!status.warn) begin
            busy <= 1'b0;  // final byte taken
            sent <= 1'b1;
          end else if (in_hdr) begin
            if (pos == HDR_LAST) begin
              in_hdr <= 1'b0;
              pos    <= '0;
            end else begin
              pos <= pos + 1'b1;
            end
          end else if (pos == REC_LAST) begin
            pos        <= '0;
            supply_idx <= supply_idx + 1'b1;  // RAM read starts now
          end else begin
            pos <= pos + 1'b1;
          end
        end
      end else begin
        in_hdr     <= 1'b1;
        pos        <= '0;
        supply_idx <= '0;
        // pending still high while sent clears it
        if (pending && !sent) begin
          busy       <= 1'b1;
          req.req    <= 1'b1;
          req.length <= pkt_len;
          nonce      <= nonce + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/setpoint_stash.sv
// Setpoint RAM between the feedback system and the transmit builder.
// Holds one frame until the builder reports it sent; frames arriving
// meanwhile are dropped whole.

`timescale 1ns/100ps

`include "fofb_consts.svh"

module setpoint_stash (
  input  logic                           ethClk,
  input  logic                           arst_n,
  input  fofb_pkg::setpoint_beat_t       beat,
  input  logic [`FOFB_ADDR_W-1:0]        raddr,
  output logic [`FOFB_VALUE_W-1:0]       rdata,
  input  logic                           sent,
  output logic                           pending,
  output logic [`FOFB_ADDR_W:0]          supply_count
);

  localparam int ADDR_W  = `FOFB_ADDR_W;
  localparam int VALUE_W = `FOFB_VALUE_W;
  localparam int DEPTH   = `FOFB_MAX_SUPPLIES;

  logic [VALUE_W-1:0] ram [0:DEPTH-1];
  logic [ADDR_W-1:0]  waddr;
  logic               toss;    // rest of current frame is discarded
  logic               accept;

  // a beat is kept only when no earlier frame is waiting
  assign accept = beat.valid && !toss && !pending;

  //////////////////////////////////////////////////
  // payload RAM, one writer and one reader
  always_ff @(posedge ethClk) begin
    if (accept) begin
      ram[waddr] <= beat.value;
    end
    rdata <= ram[raddr];  // one cycle read latency
  end

  //////////////////////////////////////////////////
  // frame write control
  always_ff @(posedge ethClk or negedge arst_n) begin
    if (!arst_n) begin
      waddr        <= '0;
      toss         <= 1'b0;
      pending      <= 1'b0;
      supply_count <= '0;
    end else begin
      if (sent) begin
        pending <= 1'b0;  // builder done, stash free again
      end
      if (beat.valid) begin
        if (toss) begin
          if (beat.last) begin
            toss <= 1'b0;
          end
        end else if (pending) begin
          // frame started while busy, drop through its last beat
          if (!beat.last) begin
            toss <= 1'b1;
          end
        end else if (beat.last) begin
          supply_count <= {1'b0, waddr} + 1'b1;  // last index plus one
          waddr        <= '0;
          pending      <= 1'b1;
        end else begin
          waddr <= waddr + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/fofb_pkg.sv
// Types passed between the setpoint stash, the transmit builder, the readback
// parser and the MAC client port.

`include "fofb_consts.svh"

package fofb_pkg;

  // one beat of a setpoint frame from the feedback system
  typedef struct packed {
    logic                     valid;
    logic                     last;   // final supply of the frame
    logic [`FOFB_VALUE_W-1:0] value;
  } setpoint_beat_t;

  // transmit request towards the MAC client
  typedef struct packed {
    logic                   req;
    logic [`FOFB_LEN_W-1:0] length;  // UDP payload bytes
  } tx_request_t;

  // transmit handshake back from the MAC client
  typedef struct packed {
    logic ack;
    logic strobe;  // one payload byte taken
    logic warn;    // low on the final byte
  } tx_status_t;

  // receive byte stream from the MAC client
  typedef struct packed {
    logic       ready;   // new packet starting
    logic       strobe;
    logic [7:0] data;
  } rx_byte_t;

  // A 6-byte supply record on the wire. bytes[0] goes out first.
  typedef union packed {
    logic [0:`FOFB_REC_BYTES-1][7:0] bytes;
    struct packed {
      logic [15:0]              supply;
      logic [`FOFB_VALUE_W-1:0] value;
    } fields;
  } supply_record_u;

  // one parsed readback record
  typedef struct packed {
    logic                     valid;
    logic [7:0]               supply;
    logic [`FOFB_VALUE_W-1:0] value;
  } rx_record_t;

endpackage

//--- hdl/fofb_consts.svh
// Sizes and payload layout shared by the fast orbit feedback link.
// Included by the package and by every module that sizes a port from them.

`ifndef FOFB_CONSTS_SVH
`define FOFB_CONSTS_SVH

//////////////////////////////////////////////////
// stash sizing
`define FOFB_MAX_SUPPLIES 32                          // supplies per frame, at most
`define FOFB_ADDR_W       $clog2(`FOFB_MAX_SUPPLIES)  // stash address bits
`define FOFB_VALUE_W      32                          // setpoint / readback word

//////////////////////////////////////////////////
// packet layout
`define FOFB_LEN_W        11                          // covers a 1500 byte payload
`define FOFB_NONCE_W      64                          // packet sequence number
`define FOFB_CMD_W        4                           // readback command code

// payload identifier, sent 0x76 first
`define FOFB_MAGIC        16'h7631

`define FOFB_HDR_BYTES    12                          // magic, command, nonce
`define FOFB_REC_BYTES    6                           // supply number plus value

`endif
